// ==== hw/frame_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_renderer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pix_en,
    input  logic [video_pkg::cnt_w-1:0]     h_cnt,
    input  logic [video_pkg::cnt_w-1:0]     v_cnt,
    input  logic                            valid,
    input  logic                            hsync_in,
    input  logic                            vsync_in,
    input  logic [1:0]                      game_state,
    input  logic [2:0]                      level,
    input  logic [game_pkg::pos_w-1:0]      p1_x,
    input  logic [game_pkg::pos_w-1:0]      p1_y,
    input  logic [game_pkg::pos_w-1:0]      p2_x,
    input  logic [game_pkg::pos_w-1:0]      p2_y,
    output logic [3*video_pkg::color_w-1:0] rgb,
    output logic                            hsync,
    output logic                            vsync
);
    import game_pkg::*;
    import video_pkg::*;

    logic [pos_w-1:0]     col, row;
    logic                 grid_line;
    logic [3*color_w-1:0] color;

    assign col = pos_w'(h_cnt / cell_shift);  // meaningful inside the active area only.
    assign row = pos_w'(v_cnt / cell_shift);
    assign grid_line = (h_cnt % cell_shift == 0) || (v_cnt % cell_shift == 0);

    always_comb begin
        if (game_state == state_menu)
            color = {4'h0, level, 1'b0, 4'h0};  // green at twice the level.
        else if (col == p1_x && row == p1_y)
            color = 12'hF00;
        else if (col == p2_x && row == p2_y)
            color = 12'h00F;
        else if (grid_line)
            color = 12'h444;
        else
            color = {4'h0, 1'b0, level, 4'h0};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else if (pix_en) begin
            rgb   <= valid ? color : '0;      // black in blanking.
            hsync <= hsync_in;
            vsync <= vsync_in;
        end
    end

endmodule

`default_nettype wire

// ==== hw/game_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       press_valid,
    input  logic [3:0]                 press_key,
    output logic [1:0]                 game_state,
    output logic [2:0]                 level,
    output logic [game_pkg::pos_w-1:0] p1_x,
    output logic [game_pkg::pos_w-1:0] p1_y,
    output logic [game_pkg::pos_w-1:0] p2_x,
    output logic [game_pkg::pos_w-1:0] p2_y
);
    import game_pkg::*;

    logic             move_p2;
    logic             blocked;
    logic [pos_w-1:0] cur_x, cur_y;
    logic [pos_w-1:0] oth_x, oth_y;
    logic [pos_w-1:0] nxt_x, nxt_y;

    // target cell of the moving player, clamped to the grid.
    always_comb begin
        move_p2 = (press_key >= key_up);      // arrows sit above the wasd indices.
        cur_x = move_p2 ? p2_x : p1_x;
        cur_y = move_p2 ? p2_y : p1_y;
        oth_x = move_p2 ? p1_x : p2_x;
        oth_y = move_p2 ? p1_y : p2_y;
        nxt_x = cur_x;
        nxt_y = cur_y;
        case (press_key)
            key_w, key_up:       if (cur_y != '0) nxt_y = cur_y - 1'b1;
            key_s, key_down:     if (cur_y != max_y) nxt_y = cur_y + 1'b1;
            key_a, key_left:     if (cur_x != '0) nxt_x = cur_x - 1'b1;
            key_d, key_right:    if (cur_x != max_x) nxt_x = cur_x + 1'b1;
            default: ;
        endcase
        blocked = (nxt_x == oth_x) && (nxt_y == oth_y);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= state_menu;
            level      <= 3'd1;
            p1_x       <= '0;
            p1_y       <= '0;
            p2_x       <= max_x;
            p2_y       <= max_y;
        end else if (press_valid) begin
            if (game_state == state_menu) begin
                case (press_key)
                    key_w: level <= (level == num_levels) ? 3'd1 : level + 3'd1;
                    key_s: level <= (level == 3'd1) ? num_levels : level - 3'd1;
                    key_enter: begin
                        game_state <= state_play;
                        p1_x       <= '0;     // opposite corners.
                        p1_y       <= '0;
                        p2_x       <= max_x;
                        p2_y       <= max_y;
                    end
                    default: ;
                endcase
            end else if (press_key == key_enter) begin
                game_state <= state_menu;     // level and positions stay.
            end else if (press_key < key_enter && !blocked) begin
                if (move_p2) begin
                    p2_x <= nxt_x;
                    p2_y <= nxt_y;
                end else begin
                    p1_x <= nxt_x;
                    p1_y <= nxt_y;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/game_pkg.sv ====
`default_nettype none

package game_pkg;

    localparam int num_keys = 10;
    localparam int ps2_timeout = 2000;        // idle clocks before a partial frame is dropped.

    // indices into the held-key vector.
    localparam logic [3:0] key_w     = 4'd0;
    localparam logic [3:0] key_a     = 4'd1;
    localparam logic [3:0] key_s     = 4'd2;
    localparam logic [3:0] key_d     = 4'd3;
    localparam logic [3:0] key_up    = 4'd4;
    localparam logic [3:0] key_left  = 4'd5;
    localparam logic [3:0] key_down  = 4'd6;
    localparam logic [3:0] key_right = 4'd7;
    localparam logic [3:0] key_enter = 4'd8;
    localparam logic [3:0] key_none  = 4'd9;  // any untracked code.

    localparam logic [7:0] prefix_ext = 8'hE0;
    localparam logic [7:0] prefix_brk = 8'hF0;

    // bit 8 marks an E0-prefixed code.
    localparam logic [8:0] code_w     = 9'h01D;
    localparam logic [8:0] code_a     = 9'h01C;
    localparam logic [8:0] code_s     = 9'h01B;
    localparam logic [8:0] code_d     = 9'h023;
    localparam logic [8:0] code_up    = 9'h175;
    localparam logic [8:0] code_left  = 9'h16B;
    localparam logic [8:0] code_down  = 9'h172;
    localparam logic [8:0] code_right = 9'h174;
    localparam logic [8:0] code_enter = 9'h05A;

    localparam logic [1:0] state_menu = 2'd0;
    localparam logic [1:0] state_play = 2'd1;

    localparam logic [2:0] num_levels = 3'd5;
    localparam int grid_cols = 16;
    localparam int grid_rows = 12;
    localparam int pos_w = 4;
    localparam logic [pos_w-1:0] max_x = pos_w'(grid_cols - 1);
    localparam logic [pos_w-1:0] max_y = pos_w'(grid_rows - 1);
    localparam int cell_shift = 40;           // cell edge in pixels, so cells come from a divide.

endpackage

`default_nettype wire

// ==== hw/game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ps2_clk,
    input  logic                          ps2_data,
    output logic [video_pkg::color_w-1:0] vga_red,
    output logic [video_pkg::color_w-1:0] vga_green,
    output logic [video_pkg::color_w-1:0] vga_blue,
    output logic                          hsync,
    output logic                          vsync,
    output logic [3:0]                    digit,
    output logic [6:0]                    segments,
    output logic [15:0]                   led
);
    import game_pkg::*;
    import video_pkg::*;

    logic [7:0]           byte_data;
    logic                 byte_valid;
    logic [num_keys-1:0]  held_keys;
    logic                 press_valid;
    logic [3:0]           press_key;
    logic [1:0]           game_state;
    logic [2:0]           level;
    logic [pos_w-1:0]     p1_x, p1_y, p2_x, p2_y;
    logic                 pix_en, valid;
    logic                 raw_hsync, raw_vsync;   // undelayed, straight from the counters.
    logic [cnt_w-1:0]     h_cnt, v_cnt;
    logic [3*color_w-1:0] rgb;

    assign {vga_red, vga_green, vga_blue} = rgb;
    assign led = {game_state, 4'b0000, held_keys};

    ps2_receiver ps2_receiver_inst (
        .clk(clk), .rst(rst),
        .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .byte_data(byte_data), .byte_valid(byte_valid)
    );

    key_tracker key_tracker_inst (
        .clk(clk), .rst(rst),
        .byte_data(byte_data), .byte_valid(byte_valid),
        .key_down(held_keys), .press_valid(press_valid), .press_key(press_key)
    );

    game_controller game_controller_inst (
        .clk(clk), .rst(rst),
        .press_valid(press_valid), .press_key(press_key),
        .game_state(game_state), .level(level),
        .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y)
    );

    vga_timing vga_timing_inst (
        .clk(clk), .rst(rst), .pix_en(pix_en),
        .h_cnt(h_cnt), .v_cnt(v_cnt),
        .hsync(raw_hsync), .vsync(raw_vsync), .valid(valid)
    );

    frame_renderer frame_renderer_inst (
        .clk(clk), .rst(rst), .pix_en(pix_en),
        .h_cnt(h_cnt), .v_cnt(v_cnt), .valid(valid),
        .hsync_in(raw_hsync), .vsync_in(raw_vsync),
        .game_state(game_state), .level(level),
        .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x), .p2_y(p2_y),
        .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

    seven_seg_scan seven_seg_scan_inst (
        .clk(clk), .rst(rst),
        .p1_x(p1_x), .p2_x(p2_x), .level(level), .game_state(game_state),
        .digit(digit), .segments(segments)
    );

endmodule

`default_nettype wire

// ==== hw/key_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_tracker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [7:0]                    byte_data,
    input  logic                          byte_valid,
    output logic [game_pkg::num_keys-1:0] key_down,
    output logic                          press_valid,
    output logic [3:0]                    press_key
);
    import game_pkg::*;

    logic       ext_flag;
    logic       brk_flag;
    logic [8:0] code;
    logic [3:0] idx;

    assign code = {ext_flag, byte_data};

    always_comb begin
        case (code)
            code_w:     idx = key_w;
            code_a:     idx = key_a;
            code_s:     idx = key_s;
            code_d:     idx = key_d;
            code_up:    idx = key_up;
            code_left:  idx = key_left;
            code_down:  idx = game_pkg::key_down;  // the port shadows the index name.
            code_right: idx = key_right;
            code_enter: idx = key_enter;
            default:    idx = key_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ext_flag    <= 1'b0;
            brk_flag    <= 1'b0;
            key_down    <= '0;
            press_valid <= 1'b0;
        end else begin
            press_valid <= 1'b0;
            if (byte_valid) begin
                if (byte_data == prefix_ext) begin
                    ext_flag <= 1'b1;
                end else if (byte_data == prefix_brk) begin
                    brk_flag <= 1'b1;
                end else begin
                    ext_flag <= 1'b0;
                    brk_flag <= 1'b0;
                    if (idx != key_none) begin
                        key_down[idx] <= ~brk_flag;
                        // typematic repeats find the bit already set.
                        press_valid   <= ~brk_flag & ~key_down[idx];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) press_key <= idx;
    end

endmodule

`default_nettype wire

// ==== hw/ps2_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] byte_data,
    output logic       byte_valid
);
    import game_pkg::*;

    logic [1:0]  clk_sync;
    logic [1:0]  data_sync;
    logic        clk_prev;
    logic        fall;
    logic        frame_ok;
    logic [3:0]  bit_cnt;
    logic [9:0]  frame;                       // start, data and parity, start at bit 0.
    logic [10:0] idle_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    // start low, stop high, odd parity over data and parity bit.
    assign frame_ok = ~frame[0] & data_sync[1] & (^frame[9:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin   // stop bit.
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0 && clk_sync[1]) begin
                if (idle_cnt == 11'(ps2_timeout - 1)) begin
                    bit_cnt  <= '0;           // keyboard went quiet mid frame.
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 11'd1;
                end
            end else begin
                idle_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && bit_cnt != 4'd10) frame <= {data_sync[1], frame[9:1]};
        if (fall && bit_cnt == 4'd10) byte_data <= frame[8:1];
    end

endmodule

`default_nettype wire

// ==== hw/seven_seg_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_seg_scan (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::pos_w-1:0] p1_x,
    input  logic [game_pkg::pos_w-1:0] p2_x,
    input  logic [2:0]                 level,
    input  logic [1:0]                 game_state,
    output logic [3:0]                 digit,
    output logic [6:0]                 segments
);
    import game_pkg::*;

    logic [11:0]      refresh;                // top two bits pick the digit.
    logic [pos_w-1:0] nib;

    always_ff @(posedge clk) begin
        if (rst) refresh <= '0;
        else     refresh <= refresh + 12'd1;
    end

    always_comb begin
        case (refresh[11:10])
            2'd0:    begin digit = 4'b1110; nib = p1_x; end
            2'd1:    begin digit = 4'b1101; nib = p2_x; end
            2'd2:    begin digit = 4'b1011; nib = {1'b0, level}; end
            default: begin digit = 4'b0111; nib = {2'b00, game_state}; end
        endcase
    end

    // segments are {g,f,e,d,c,b,a}, low lights a bar.
    always_comb begin
        case (nib)
            4'h0: segments = 7'b1000000;
            4'h1: segments = 7'b1111001;
            4'h2: segments = 7'b0100100;
            4'h3: segments = 7'b0110000;
            4'h4: segments = 7'b0011001;
            4'h5: segments = 7'b0010010;
            4'h6: segments = 7'b0000010;
            4'h7: segments = 7'b1111000;
            4'h8: segments = 7'b0000000;
            4'h9: segments = 7'b0010000;
            4'hA: segments = 7'b0001000;
            4'hB: segments = 7'b0000011;
            4'hC: segments = 7'b1000110;
            4'hD: segments = 7'b0100001;
            4'hE: segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        pix_en,
    output logic [video_pkg::cnt_w-1:0] h_cnt,
    output logic [video_pkg::cnt_w-1:0] v_cnt,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        valid
);
    import video_pkg::*;

    logic [$clog2(pix_div)-1:0] div_cnt;

    assign pix_en = (div_cnt == ($clog2(pix_div))'(pix_div - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;        // wraps at pix_div.
            if (pix_en) begin
                if (h_cnt == h_total - 1'b1) begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == v_total - 1'b1) ? '0 : v_cnt + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end
        end
    end

    // both syncs active low.
    assign hsync = ~((h_cnt >= h_active + h_front) && (h_cnt < h_active + h_front + h_sync));
    assign vsync = ~((v_cnt >= v_active + v_front) && (v_cnt < v_active + v_front + v_sync));
    assign valid = (h_cnt < h_active) && (v_cnt < v_active);

endmodule

`default_nettype wire

// ==== hw/video_pkg.sv ====
`default_nettype none

package video_pkg;

    localparam int cnt_w = 10;
    localparam int color_w = 4;
    localparam int pix_div = 4;               // 100 MHz down to the 25 MHz pixel rate.

    localparam logic [cnt_w-1:0] h_active = 10'd640;
    localparam logic [cnt_w-1:0] h_front  = 10'd16;
    localparam logic [cnt_w-1:0] h_sync   = 10'd96;
    localparam logic [cnt_w-1:0] h_back   = 10'd48;
    localparam logic [cnt_w-1:0] h_total  = h_active + h_front + h_sync + h_back;

    localparam logic [cnt_w-1:0] v_active = 10'd480;
    localparam logic [cnt_w-1:0] v_front  = 10'd10;
    localparam logic [cnt_w-1:0] v_sync   = 10'd2;
    localparam logic [cnt_w-1:0] v_back   = 10'd33;
    localparam logic [cnt_w-1:0] v_total  = v_active + v_front + v_sync + v_back;

endpackage

`default_nettype wire

// ==== list.f ====
hw/game_pkg.sv
hw/video_pkg.sv
hw/ps2_receiver.sv
hw/key_tracker.sv
hw/game_controller.sv
hw/vga_timing.sv
hw/frame_renderer.sv
hw/seven_seg_scan.sv
hw/game_top.sv
tests/game_checker.sv
tests/tb_game_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_game_top -f list.f
out=$(./obj_dir/Vtb_game_top)
echo "$out"
echo "$out" | grep -q "RESULT: PASS"

// ==== tests/game_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_checker (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        hsync,
    input wire logic        vsync,
    input wire logic [11:0] rgb,
    input wire logic [3:0]  digit,
    input wire logic [6:0]  segments,
    input wire logic [15:0] led
);
    logic        hs_prev;
    logic        hs_fell;
    logic        hs_rose;
    logic        seen_fall;                   // a full period is only known after one fall.
    logic [11:0] low_cnt;
    logic [12:0] period_cnt;

    assign hs_fell = hs_prev & ~hsync;
    assign hs_rose = ~hs_prev & hsync;

    always_ff @(posedge clk) begin
        if (rst) begin
            hs_prev    <= 1'b1;
            seen_fall  <= 1'b0;
            low_cnt    <= '0;
            period_cnt <= '0;
        end else begin
            hs_prev    <= hsync;
            seen_fall  <= seen_fall | hs_fell;
            low_cnt    <= hsync ? 12'd0 : low_cnt + 12'd1;
            period_cnt <= hs_fell ? 13'd0 : period_cnt + 13'd1;
        end
    end

    // black whenever either sync is active.
    assert property (@(posedge clk) disable iff (rst) (!hsync || !vsync) |-> rgb == 12'h000)
        else $error("rgb %h is not black during sync", rgb);

    // 96 pixels at four clocks each.
    assert property (@(posedge clk) disable iff (rst) hs_rose |-> low_cnt == 12'd384)
        else $error("hsync low pulse lasted %0d clocks", low_cnt);

    assert property (@(posedge clk) disable iff (rst)
        (hs_fell && seen_fall) |-> period_cnt == 13'd3199)
        else $error("hsync period was %0d clocks", period_cnt + 13'd1);

    assert property (@(posedge clk) disable iff (rst)
        !$isunknown({hsync, vsync, rgb, digit, segments, led}))
        else $error("unknown value on a game_top output");

endmodule

bind game_top game_checker game_checker_inst (
    .clk(clk), .rst(rst), .hsync(hsync), .vsync(vsync),
    .rgb({vga_red, vga_green, vga_blue}),
    .digit(digit), .segments(segments), .led(led)
);

`default_nettype wire

// ==== tests/tb_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_game_top;
    // about 220 bytes of 1000 clocks, 60 display reads of up to 4096 clocks, 8 video lines.
    localparam int timeout_cycles = 220 * 1000 + 60 * 4096 + 8 * 3200;

    logic clk, rst, ps2_clk, ps2_data;
    wire logic [3:0]  vga_red, vga_green, vga_blue, digit;
    wire logic        hsync, vsync;
    wire logic [6:0]  segments;
    wire logic [15:0] led;
    logic [11:0] rgb;
    int          errors;
    int          checks;
    int          cycles = 0;
    logic [31:0] lfsr;
    logic [2:0]  level;
    logic [1:0]  state;
    logic [3:0]  p1x, p1y, p2x, p2y;

    assign rgb = {vga_red, vga_green, vga_blue};

    game_top game_top_inst (
        .clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
        .hsync(hsync), .vsync(vsync), .digit(digit), .segments(segments), .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    // one lfsr step per bit taken.
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    function automatic logic [8:0] code_of(input logic [3:0] idx);
        case (idx)
            0: code_of = 9'h01D;
            1: code_of = 9'h01C;
            2: code_of = 9'h01B;
            3: code_of = 9'h023;
            4: code_of = 9'h175;
            5: code_of = 9'h16B;
            6: code_of = 9'h172;
            7: code_of = 9'h174;
            default: code_of = 9'h05A;
        endcase
    endfunction

    function automatic logic [4:0] hex_of(input logic [6:0] seg);
        case (seg)
            7'b1000000: hex_of = 5'h0;
            7'b1111001: hex_of = 5'h1;
            7'b0100100: hex_of = 5'h2;
            7'b0110000: hex_of = 5'h3;
            7'b0011001: hex_of = 5'h4;
            7'b0010010: hex_of = 5'h5;
            7'b0000010: hex_of = 5'h6;
            7'b1111000: hex_of = 5'h7;
            7'b0000000: hex_of = 5'h8;
            7'b0010000: hex_of = 5'h9;
            7'b0001000: hex_of = 5'hA;
            7'b0000011: hex_of = 5'hB;
            7'b1000110: hex_of = 5'hC;
            7'b0100001: hex_of = 5'hD;
            7'b0000110: hex_of = 5'hE;
            7'b0001110: hex_of = 5'hF;
            default:    hex_of = 5'h1F;       // not a hex glyph.
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // frame is start, data lsb first, odd parity, stop.
    task automatic send_byte(input logic [7:0] b, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~(^b) ^ bad_parity, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (40) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (40) @(negedge clk);
            ps2_clk = 1'b1;
        end
        repeat (100) @(negedge clk);
    endtask

    task automatic send_make(input logic [3:0] idx);
        logic [8:0] code;
        code = code_of(idx);
        if (code[8]) send_byte(8'hE0, 1'b0);
        send_byte(code[7:0], 1'b0);
    endtask

    task automatic send_break(input logic [3:0] idx);
        logic [8:0] code;
        code = code_of(idx);
        if (code[8]) send_byte(8'hE0, 1'b0);
        send_byte(8'hF0, 1'b0);
        send_byte(code[7:0], 1'b0);
    endtask

    // reference model of the game rules.
    task automatic apply_press(input logic [3:0] idx);
        logic [4:0] nx, ny;
        logic       second;
        if (state == 2'd0) begin
            if (idx == 0) level = (level == 5) ? 3'd1 : level + 3'd1;
            else if (idx == 2) level = (level == 1) ? 3'd5 : level - 3'd1;
            else if (idx == 8) begin
                state = 2'd1;
                p1x = 0;
                p1y = 0;
                p2x = 15;
                p2y = 11;
            end
        end else if (idx == 8) begin
            state = 2'd0;
        end else begin
            second = idx >= 4;
            nx = second ? p2x : p1x;
            ny = second ? p2y : p1y;
            case (idx % 4)
                0: if (ny > 0) ny = ny - 1;
                1: if (nx > 0) nx = nx - 1;
                2: if (ny < 11) ny = ny + 1;
                default: if (nx < 15) nx = nx + 1;
            endcase
            if (second && !(nx == p1x && ny == p1y)) begin
                p2x = nx[3:0];
                p2y = ny[3:0];
            end else if (!second && !(nx == p2x && ny == p2y)) begin
                p1x = nx[3:0];
                p1y = ny[3:0];
            end
        end
    endtask

    task automatic tap_key(input logic [3:0] idx);
        send_make(idx);
        apply_press(idx);
        send_break(idx);
    endtask

    task automatic read_digit(input int n, output logic [4:0] v);
        do @(negedge clk); while (digit != ~(4'b0001 << n));
        v = hex_of(segments);
    endtask

    task automatic check_display();
        logic [4:0] v;
        read_digit(0, v);
        check_value("digit0 p1_x", 16'(v), 16'(p1x));
        read_digit(1, v);
        check_value("digit1 p2_x", 16'(v), 16'(p2x));
        read_digit(2, v);
        check_value("digit2 level", 16'(v), 16'(level));
        read_digit(3, v);
        check_value("digit3 state", 16'(v), 16'(state));
        check_value("led[15:14]", 16'(led[15:14]), 16'(state));
    endtask

    initial begin
        logic [7:0] r;
        logic [3:0] rep;
        errors = 0;
        checks = 0;
        lfsr = 32'h5bc7_dce0;
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        level = 1;
        state = 0;
        p1x = 0;
        p1y = 0;
        p2x = 15;
        p2y = 11;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("led", led, 16'h0000);
        check_value("hsync", 16'(hsync), 16'h1);
        check_value("vsync", 16'(vsync), 16'h1);
        check_value("rgb", 16'(rgb), 16'h000);
        check_display();

        send_make(3);                         // menu ignores d.
        check_value("led", led, 16'h0008);
        send_break(3);
        check_value("led", led, 16'h0000);
        send_make(7);
        check_value("led", led, 16'h0080);
        send_break(7);
        check_value("led", led, 16'h0000);
        send_byte(8'h23, 1'b1);               // parity broken on purpose.
        check_value("led", led, 16'h0000);

        tap_key(2);
        check_display();
        tap_key(0);
        check_display();
        tap_key(0);
        tap_key(8);
        check_display();

        // player 1 walks to the cell left of player 2, then tries to step onto it.
        repeat (14) tap_key(3);
        repeat (11) tap_key(2);
        tap_key(3);
        check_display();

        for (int i = 0; i < 20; i++) begin
            take_bits(3, r);
            tap_key(r[3:0]);
            check_display();
        end

        // typematic repeat moves only once, heading away from the nearer edge.
        rep = (p1x < 4'd8) ? 4'd3 : 4'd1;
        send_make(rep);
        apply_press(rep);
        send_make(rep);
        send_break(rep);
        check_display();

        repeat (6 * 3200) begin
            @(negedge clk);
            checks++;
            assert (rgb == 12'h000 || rgb == 12'hF00 || rgb == 12'h00F ||
                    rgb == 12'h444 || rgb == {4'h0, 1'b0, level, 4'h0}) else begin
                errors++;
                $display("FAILED rgb: got %h, not a play-state color", rgb);
            end
        end

        tap_key(8);
        check_display();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
